// File: source/simt_isa_pkg.sv
package simt_isa_pkg;

	// ********************
	// instruction format
	// ********************

	localparam int num_regs = 32;

	typedef logic [4:0] reg_addr_t;

	// register-register operations come first, the immediate forms last.
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_sll  = 4'd5,
		op_srl  = 4'd6,
		op_addi = 4'd7,
		op_lui  = 4'd8
	} opcode_e;

	// the thread mask travels beside this struct, its width follows num_threads.
	typedef struct packed {
		opcode_e     opcode;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic [19:0] imm;
	} instr_t;

endpackage

// File: source/simt_lane_pkg.sv
package simt_lane_pkg;

	// ********************
	// lane data
	// ********************

	// lane arrays are sized for the widest warp, unused lanes stay zero.
	localparam int max_threads = 8;

	typedef logic [31:0] word_t;

	// decode to execute.
	typedef struct packed {
		simt_isa_pkg::opcode_e   opcode;
		simt_isa_pkg::reg_addr_t rd;
		logic [19:0]             imm;
		logic [max_threads-1:0]  mask;
		word_t [max_threads-1:0] a;
		word_t [max_threads-1:0] b;
	} exec_op_t;

	// execute to writeback, and the result leaving the core.
	typedef struct packed {
		simt_isa_pkg::reg_addr_t rd;
		logic [max_threads-1:0]  mask;
		word_t [max_threads-1:0] data;
	} result_t;

endpackage

// File: source/simt_gpr.sv
`timescale 1ns/10ps

module simt_gpr #(
	parameter int num_threads = 4
) (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  simt_isa_pkg::reg_addr_t                 rd_addr_a,
	input  simt_isa_pkg::reg_addr_t                 rd_addr_b,
	output simt_lane_pkg::word_t [num_threads-1:0] rd_data_a,
	output simt_lane_pkg::word_t [num_threads-1:0] rd_data_b,
	input  logic                                    wr_en,
	input  simt_isa_pkg::reg_addr_t                 wr_addr,
	input  logic [num_threads-1:0]                  wr_lane_en,
	input  simt_lane_pkg::word_t [num_threads-1:0] wr_data
);

	logic wr_ok;

	// r0 is never written, so it keeps the zero loaded at reset.
	assign wr_ok = wr_en && (wr_addr != '0);

	for (genvar t = 0; t < num_threads; t++)
	begin : g_thread
		simt_lane_pkg::word_t mem [simt_isa_pkg::num_regs];
		simt_lane_pkg::word_t q_a;
		simt_lane_pkg::word_t q_b;

		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				for (int r = 0; r < simt_isa_pkg::num_regs; r++)
				begin
					mem[r] <= '0;
				end
			end
			else if (wr_ok && wr_lane_en[t])
			begin
				mem[wr_addr] <= wr_data[t];
			end
		end

		// registered reads see the storage as it was before this edge.
		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				q_a <= '0;
				q_b <= '0;
			end
			else
			begin
				q_a <= mem[rd_addr_a];
				q_b <= mem[rd_addr_b];
			end
		end

		assign rd_data_a[t] = q_a;
		assign rd_data_b[t] = q_b;
	end

endmodule

// File: source/simt_decode.sv
`timescale 1ns/10ps

module simt_decode #(
	parameter int num_threads = 4
) (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    in_valid,
	output logic                                    in_ready,
	input  simt_isa_pkg::instr_t                    in_instr,
	input  logic [num_threads-1:0]                  in_mask,
	output simt_isa_pkg::reg_addr_t                 gpr_addr_a,
	output simt_isa_pkg::reg_addr_t                 gpr_addr_b,
	input  simt_lane_pkg::word_t [num_threads-1:0] gpr_data_a,
	input  simt_lane_pkg::word_t [num_threads-1:0] gpr_data_b,
	input  simt_isa_pkg::reg_addr_t                 ex_rd,
	input  logic                                    ex_busy,
	input  simt_isa_pkg::reg_addr_t                 wb_rd,
	input  logic                                    wb_busy,
	output logic                                    dec_valid,
	input  logic                                    dec_ready,
	output simt_lane_pkg::exec_op_t                 dec_op
);

	logic ready_en;
	logic s1_valid;
	logic s1_fresh;
	simt_isa_pkg::opcode_e s1_opcode;
	simt_isa_pkg::reg_addr_t s1_rd;
	logic [19:0] s1_imm;
	logic [simt_lane_pkg::max_threads-1:0] s1_mask;
	logic [simt_lane_pkg::max_threads-1:0] in_mask_wide;
	simt_lane_pkg::word_t [num_threads-1:0] hold_a;
	simt_lane_pkg::word_t [num_threads-1:0] hold_b;
	simt_lane_pkg::exec_op_t next_op;
	logic s1_busy;
	logic dec_busy;
	logic hazard;
	logic dec_load;
	logic s1_move;
	logic accept;

	function automatic logic depends(simt_isa_pkg::instr_t instr,
		simt_isa_pkg::reg_addr_t rd, logic busy);
		return busy && ((instr.rs1 == rd) || (instr.rs2 == rd));
	endfunction

	// ********************
	// hazard check and handshake
	// ********************

	assign gpr_addr_a = in_instr.rs1;
	assign gpr_addr_b = in_instr.rs2;

	assign s1_busy  = s1_valid && (s1_rd != '0) && (|s1_mask);
	assign dec_busy = dec_valid && (dec_op.rd != '0) && (|dec_op.mask);

	assign hazard = depends(in_instr, s1_rd, s1_busy) ||
		depends(in_instr, dec_op.rd, dec_busy) ||
		depends(in_instr, ex_rd, ex_busy) ||
		depends(in_instr, wb_rd, wb_busy);

	assign dec_load = !dec_valid || dec_ready;
	assign s1_move  = s1_valid && dec_load;
	assign in_ready = ready_en && (!s1_valid || s1_move) && !hazard;
	assign accept   = in_valid && in_ready;

	always_comb
	begin
		in_mask_wide = '0;
		in_mask_wide[num_threads-1:0] = in_mask;
	end

	// ********************
	// operand join
	// ********************

	// operands come straight from the register file in the cycle after
	// acceptance, and from the holding copy once that cycle has passed.
	always_comb
	begin
		next_op = '0;
		next_op.opcode = s1_opcode;
		next_op.rd = s1_rd;
		next_op.imm = s1_imm;
		next_op.mask = s1_mask;
		for (int t = 0; t < num_threads; t++)
		begin
			next_op.a[t] = s1_fresh ? gpr_data_a[t] : hold_a[t];
			next_op.b[t] = s1_fresh ? gpr_data_b[t] : hold_b[t];
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ready_en <= 1'b0;
			s1_valid <= 1'b0;
			s1_fresh <= 1'b0;
			dec_valid <= 1'b0;
		end
		else
		begin
			ready_en <= 1'b1;
			s1_fresh <= accept;
			if (accept)
				s1_valid <= 1'b1;
			else if (s1_move)
				s1_valid <= 1'b0;
			if (dec_load)
				dec_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1_opcode <= in_instr.opcode;
			s1_rd <= in_instr.rd;
			s1_imm <= in_instr.imm;
			s1_mask <= in_mask_wide;
		end
		if (s1_fresh)
		begin
			hold_a <= gpr_data_a;
			hold_b <= gpr_data_b;
		end
		if (s1_move)
			dec_op <= next_op;
	end

endmodule

// File: source/simt_execute.sv
`timescale 1ns/10ps

module simt_execute #(
	parameter int num_threads = 4
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    dec_valid,
	output logic                    dec_ready,
	input  simt_lane_pkg::exec_op_t dec_op,
	output logic                    ex_valid,
	input  logic                    ex_ready,
	output simt_lane_pkg::result_t  ex_result,
	output simt_isa_pkg::reg_addr_t ex_rd,
	output logic                    ex_busy
);

	simt_lane_pkg::result_t next_result;

	// ********************
	// lane ALU
	// ********************

	function automatic simt_lane_pkg::word_t alu(simt_isa_pkg::opcode_e op,
		simt_lane_pkg::word_t a, simt_lane_pkg::word_t b, logic [19:0] imm);
		simt_lane_pkg::word_t imm_sext;
		simt_lane_pkg::word_t res;
		imm_sext = {{12{imm[19]}}, imm};
		case (op)
			simt_isa_pkg::op_add:
				res = a + b;
			simt_isa_pkg::op_sub:
				res = a - b;
			simt_isa_pkg::op_and:
				res = a & b;
			simt_isa_pkg::op_or:
				res = a | b;
			simt_isa_pkg::op_xor:
				res = a ^ b;
			// shift amounts use only the low five bits of rs2.
			simt_isa_pkg::op_sll:
				res = a << b[4:0];
			simt_isa_pkg::op_srl:
				res = a >> b[4:0];
			simt_isa_pkg::op_addi:
				res = a + imm_sext;
			simt_isa_pkg::op_lui:
				res = {imm, 12'h000};
			default:
				res = '0;
		endcase
		return res;
	endfunction

	// lanes above num_threads stay zero.
	always_comb
	begin
		next_result = '0;
		next_result.rd = dec_op.rd;
		next_result.mask = dec_op.mask;
		for (int t = 0; t < num_threads; t++)
		begin
			next_result.data[t] = alu(dec_op.opcode, dec_op.a[t], dec_op.b[t], dec_op.imm);
		end
	end

	// ********************
	// stage register
	// ********************

	assign dec_ready = !ex_valid || ex_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ex_valid <= 1'b0;
		else if (dec_ready)
			ex_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid && dec_ready)
			ex_result <= next_result;
	end

	// pending destination, seen by the hazard check in decode.
	assign ex_rd   = ex_result.rd;
	assign ex_busy = ex_valid && (ex_result.rd != '0) && (|ex_result.mask);

endmodule

// File: source/simt_writeback.sv
`timescale 1ns/10ps

module simt_writeback #(
	parameter int num_threads = 4
) (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    ex_valid,
	output logic                                    ex_ready,
	input  simt_lane_pkg::result_t                  ex_result,
	output logic                                    out_valid,
	input  logic                                    out_ready,
	output simt_lane_pkg::result_t                  out_result,
	output simt_isa_pkg::reg_addr_t                 wb_rd,
	output logic                                    wb_busy,
	output logic                                    gpr_wr_en,
	output simt_isa_pkg::reg_addr_t                 gpr_wr_addr,
	output logic [num_threads-1:0]                  gpr_wr_lane_en,
	output simt_lane_pkg::word_t [num_threads-1:0] gpr_wr_data
);

	// the result waits here until the output side takes it.
	assign ex_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (ex_ready)
			out_valid <= ex_valid;
	end

	always_ff @(posedge clk)
	begin
		if (ex_valid && ex_ready)
			out_result <= ex_result;
	end

	// ********************
	// register file commit
	// ********************

	// the commit lands on the same edge as the output transfer.
	assign gpr_wr_en      = out_valid && out_ready;
	assign gpr_wr_addr    = out_result.rd;
	assign gpr_wr_lane_en = out_result.mask[num_threads-1:0];
	assign gpr_wr_data    = out_result.data[num_threads-1:0];

	assign wb_rd   = out_result.rd;
	assign wb_busy = out_valid && (out_result.rd != '0) && (|out_result.mask);

endmodule

// File: source/simt_core.sv
`timescale 1ns/10ps

module simt_core #(
	parameter int num_threads = 4
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  simt_isa_pkg::instr_t   in_instr,
	input  logic [num_threads-1:0] in_mask,
	output logic                   out_valid,
	input  logic                   out_ready,
	output simt_lane_pkg::result_t out_result
);

	simt_isa_pkg::reg_addr_t gpr_addr_a;
	simt_isa_pkg::reg_addr_t gpr_addr_b;
	simt_lane_pkg::word_t [num_threads-1:0] gpr_data_a;
	simt_lane_pkg::word_t [num_threads-1:0] gpr_data_b;
	logic gpr_wr_en;
	simt_isa_pkg::reg_addr_t gpr_wr_addr;
	logic [num_threads-1:0] gpr_wr_lane_en;
	simt_lane_pkg::word_t [num_threads-1:0] gpr_wr_data;

	logic dec_valid;
	logic dec_ready;
	simt_lane_pkg::exec_op_t dec_op;
	logic ex_valid;
	logic ex_ready;
	simt_lane_pkg::result_t ex_result;
	simt_isa_pkg::reg_addr_t ex_rd;
	logic ex_busy;
	simt_isa_pkg::reg_addr_t wb_rd;
	logic wb_busy;

	// ********************
	// pipeline stages
	// ********************

	simt_decode #(.num_threads(num_threads)) u_decode (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr), .in_mask(in_mask),
		.gpr_addr_a(gpr_addr_a), .gpr_addr_b(gpr_addr_b),
		.gpr_data_a(gpr_data_a), .gpr_data_b(gpr_data_b),
		.ex_rd(ex_rd), .ex_busy(ex_busy), .wb_rd(wb_rd), .wb_busy(wb_busy),
		.dec_valid(dec_valid), .dec_ready(dec_ready), .dec_op(dec_op)
	);

	simt_gpr #(.num_threads(num_threads)) u_gpr (
		.clk(clk), .arst_n(arst_n),
		.rd_addr_a(gpr_addr_a), .rd_addr_b(gpr_addr_b),
		.rd_data_a(gpr_data_a), .rd_data_b(gpr_data_b),
		.wr_en(gpr_wr_en), .wr_addr(gpr_wr_addr),
		.wr_lane_en(gpr_wr_lane_en), .wr_data(gpr_wr_data)
	);

	simt_execute #(.num_threads(num_threads)) u_execute (
		.clk(clk), .arst_n(arst_n),
		.dec_valid(dec_valid), .dec_ready(dec_ready), .dec_op(dec_op),
		.ex_valid(ex_valid), .ex_ready(ex_ready), .ex_result(ex_result),
		.ex_rd(ex_rd), .ex_busy(ex_busy)
	);

	simt_writeback #(.num_threads(num_threads)) u_writeback (
		.clk(clk), .arst_n(arst_n),
		.ex_valid(ex_valid), .ex_ready(ex_ready), .ex_result(ex_result),
		.out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
		.wb_rd(wb_rd), .wb_busy(wb_busy),
		.gpr_wr_en(gpr_wr_en), .gpr_wr_addr(gpr_wr_addr),
		.gpr_wr_lane_en(gpr_wr_lane_en), .gpr_wr_data(gpr_wr_data)
	);

endmodule

// File: testbench/simt_core_assertions.sv
`timescale 1ns/10ps

module simt_core_assertions (
	input logic                    clk,
	input logic                    arst_n,
	input logic                    in_valid,
	input logic                    in_ready,
	input simt_isa_pkg::instr_t    in_instr,
	input logic                    in_mask_any,
	input logic                    out_valid,
	input logic                    out_ready,
	input simt_lane_pkg::result_t  out_result,
	input logic                    dec_valid,
	input logic                    dec_ready,
	input simt_lane_pkg::exec_op_t dec_op,
	input simt_isa_pkg::reg_addr_t ex_rd,
	input logic                    ex_busy,
	input simt_isa_pkg::reg_addr_t wb_rd,
	input logic                    wb_busy
);

	int fail_count = 0;
	int in_flight;
	logic fetch_valid;
	logic fetch_busy;
	simt_isa_pkg::reg_addr_t fetch_rd;
	logic dec_busy;
	logic hazard;

	function automatic logic reads_reg(simt_isa_pkg::instr_t instr,
		simt_isa_pkg::reg_addr_t rd);
		return (instr.rs1 == rd) || (instr.rs2 == rd);
	endfunction

	// the instruction accepted last, until decode hands it to its output register.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fetch_valid <= 1'b0;
			fetch_busy <= 1'b0;
			fetch_rd <= '0;
		end
		else if (in_valid && in_ready)
		begin
			fetch_valid <= 1'b1;
			fetch_busy <= (in_instr.rd != '0) && in_mask_any;
			fetch_rd <= in_instr.rd;
		end
		else if (!dec_valid || dec_ready)
			fetch_valid <= 1'b0;
	end

	assign dec_busy = dec_valid && (dec_op.rd != '0) && (|dec_op.mask);
	assign hazard = (fetch_valid && fetch_busy && reads_reg(in_instr, fetch_rd)) ||
		(dec_busy && reads_reg(in_instr, dec_op.rd)) ||
		(ex_busy && reads_reg(in_instr, ex_rd)) ||
		(wb_busy && reads_reg(in_instr, wb_rd));

	// instructions accepted and not yet delivered at the output.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			in_flight <= 0;
		else
			in_flight <= in_flight + ((in_valid && in_ready) ? 1 : 0) -
				((out_valid && out_ready) ? 1 : 0);
	end

	// ********************
	// protocol checks
	// ********************

	a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_result))
	else
	begin
		fail_count = fail_count + 1;
		$error("out_result or out_valid changed while the output was stalled");
	end

	a_reset_idle: assert property (@(posedge clk) !arst_n |-> !in_ready && !out_valid)
	else
	begin
		fail_count = fail_count + 1;
		$error("in_ready or out_valid high during reset");
	end

	a_first_cycle: assert property (@(posedge clk) $rose(arst_n) |-> !in_ready)
	else
	begin
		fail_count = fail_count + 1;
		$error("in_ready high in the first cycle after reset");
	end

	a_hazard_stall: assert property (@(posedge clk) disable iff (!arst_n)
		hazard |-> !in_ready)
	else
	begin
		fail_count = fail_count + 1;
		$error("in_ready high while a source register is still in flight");
	end

	a_out_origin: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> in_flight > 0)
	else
	begin
		fail_count = fail_count + 1;
		$error("out_valid without an accepted instruction");
	end

endmodule

bind simt_core simt_core_assertions u_sva (
	.clk(clk), .arst_n(arst_n),
	.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
	.in_mask_any(|in_mask),
	.out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
	.dec_valid(dec_valid), .dec_ready(dec_ready), .dec_op(dec_op),
	.ex_rd(ex_rd), .ex_busy(ex_busy), .wb_rd(wb_rd), .wb_busy(wb_busy)
);

// File: testbench/simt_core_tb.sv
`timescale 1ns/10ps

module simt_core_tb;

	localparam int num_threads = 4;
	// about 70 instructions, each far below 50 cycles even with a slow output side.
	localparam int cycle_limit = 4000;

	logic clk = 1'b0;
	logic arst_n;
	logic in_valid;
	logic in_ready;
	simt_isa_pkg::instr_t in_instr;
	logic [num_threads-1:0] in_mask;
	logic out_valid;
	logic out_ready;
	simt_lane_pkg::result_t out_result;

	int unsigned ready_pct = 75;
	int issued = 0;
	int received = 0;
	int cycles = 0;
	simt_isa_pkg::instr_t instr_q[$];
	logic [num_threads-1:0] mask_q[$];
	string name_q[$];
	simt_lane_pkg::word_t ref_regs [num_threads][32] = '{default: '0};

	simt_core #(.num_threads(num_threads)) uut (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr), .in_mask(in_mask),
		.out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
	);

	always #5 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_word(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (expected == actual)
		else
			fail_run($sformatf("ERR %s %s: expected %h actual %h", name, what, expected, actual));
	endtask

	// expected lane result, written from the opcode rules of the ISA.
	function automatic simt_lane_pkg::word_t lane_value(simt_isa_pkg::opcode_e op,
		simt_lane_pkg::word_t a, simt_lane_pkg::word_t b, logic [19:0] imm);
		simt_lane_pkg::word_t imm_ext;
		imm_ext = imm[19] ? {12'hfff, imm} : {12'h000, imm};
		case (op)
			simt_isa_pkg::op_add: return a + b;
			simt_isa_pkg::op_sub: return a + ~b + 32'd1;
			simt_isa_pkg::op_and: return a & b;
			simt_isa_pkg::op_or: return a | b;
			simt_isa_pkg::op_xor: return a ^ b;
			simt_isa_pkg::op_sll: return a << (b % 32);
			simt_isa_pkg::op_srl: return a >> (b % 32);
			simt_isa_pkg::op_addi: return a + imm_ext;
			simt_isa_pkg::op_lui: return simt_lane_pkg::word_t'(imm) << 12;
			default: return '0;
		endcase
	endfunction

	task automatic check_output();
		simt_isa_pkg::instr_t ins;
		logic [num_threads-1:0] mask;
		string name;
		simt_lane_pkg::word_t expected;
		if (instr_q.size() == 0)
			fail_run("an output transfer arrived with no instruction in flight");
		else
		begin
			ins = instr_q.pop_front();
			mask = mask_q.pop_front();
			name = name_q.pop_front();
			check_word(name, "rd", 32'(ins.rd), 32'(out_result.rd));
			check_word(name, "mask", 32'(mask), 32'(out_result.mask));
			for (int t = 0; t < simt_lane_pkg::max_threads; t++)
			begin
				if (t >= num_threads)
					check_word(name, $sformatf("unused lane %0d", t), '0, out_result.data[t]);
				else if (mask[t])
				begin
					expected = lane_value(ins.opcode, ref_regs[t][ins.rs1], ref_regs[t][ins.rs2],
						ins.imm);
					check_word(name, $sformatf("lane %0d", t), expected, out_result.data[t]);
					if (ins.rd != '0)
						ref_regs[t][ins.rd] = expected;
				end
			end
			received++;
		end
	endtask

	// holds in_valid until the core takes the instruction.
	task automatic issue(input string name, input simt_isa_pkg::opcode_e op,
		input int rd, input int rs1, input int rs2, input logic [19:0] imm,
		input logic [num_threads-1:0] mask);
		logic taken;
		in_instr.opcode = op;
		in_instr.rd = simt_isa_pkg::reg_addr_t'(rd);
		in_instr.rs1 = simt_isa_pkg::reg_addr_t'(rs1);
		in_instr.rs2 = simt_isa_pkg::reg_addr_t'(rs2);
		in_instr.imm = imm;
		in_mask = mask;
		in_valid = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = in_ready;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		instr_q.push_back(in_instr);
		mask_q.push_back(mask);
		name_q.push_back(name);
		issued++;
	endtask

	// outputs are stable at the falling edge, so the transfer is known before it happens.
	always @(negedge clk)
	begin
		if (arst_n && out_valid && out_ready)
			check_output();
		if (uut.u_sva.fail_count != 0)
			fail_run("a bound protocol assertion failed");
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
			fail_run("timeout, the run did not finish within the cycle limit");
	end

	initial
	begin
		out_ready = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			out_ready = ($urandom % 100) < ready_pct;
		end
	end

	initial
	begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		in_mask = '0;
		void'($urandom(32'h0571877c));
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// ********************
		// directed tests
		// ********************
		issue("reset_zero", simt_isa_pkg::op_add, 3, 1, 2, 20'h0, 4'hf);
		// partial masks make the lanes hold different values.
		issue("load", simt_isa_pkg::op_addi, 1, 0, 0, 20'h00123, 4'hf);
		issue("load", simt_isa_pkg::op_addi, 1, 1, 0, 20'hffffb, 4'h5);
		issue("load", simt_isa_pkg::op_lui, 2, 0, 0, 20'habcde, 4'hf);
		issue("load", simt_isa_pkg::op_addi, 2, 2, 0, 20'h00345, 4'ha);
		issue("load", simt_isa_pkg::op_addi, 4, 0, 0, 20'h00024, 4'hf);
		issue("load", simt_isa_pkg::op_addi, 4, 4, 0, 20'h00003, 4'h3);
		issue("alu_add", simt_isa_pkg::op_add, 5, 1, 2, 20'h0, 4'hf);
		issue("alu_sub", simt_isa_pkg::op_sub, 6, 1, 2, 20'h0, 4'hf);
		issue("alu_and", simt_isa_pkg::op_and, 7, 1, 2, 20'h0, 4'hf);
		issue("alu_or", simt_isa_pkg::op_or, 8, 1, 2, 20'h0, 4'hf);
		issue("alu_xor", simt_isa_pkg::op_xor, 9, 1, 2, 20'h0, 4'hf);
		issue("alu_sll", simt_isa_pkg::op_sll, 10, 2, 4, 20'h0, 4'hf);
		issue("alu_srl", simt_isa_pkg::op_srl, 11, 2, 4, 20'h0, 4'hf);
		issue("lane_mask", simt_isa_pkg::op_addi, 12, 0, 0, 20'h00111, 4'hf);
		issue("lane_mask", simt_isa_pkg::op_addi, 12, 0, 0, 20'h00222, 4'h6);
		issue("lane_mask", simt_isa_pkg::op_or, 13, 12, 0, 20'h0, 4'hf);
		issue("r0_write", simt_isa_pkg::op_addi, 0, 0, 0, 20'h007ff, 4'hf);
		issue("r0_read", simt_isa_pkg::op_add, 14, 0, 0, 20'h0, 4'hf);
		issue("chain", simt_isa_pkg::op_addi, 16, 0, 0, 20'h00001, 4'hf);
		for (int i = 0; i < 4; i++)
			issue("chain", simt_isa_pkg::op_addi, 16, 16, 0, 20'h00001, 4'hf);
		issue("chain", simt_isa_pkg::op_add, 17, 16, 16, 20'h0, 4'hf);
		issue("chain", simt_isa_pkg::op_sll, 18, 17, 16, 20'h0, 4'hf);

		// ********************
		// random stream
		// ********************
		ready_pct = 50;
		for (int i = 0; i < 40; i++)
		begin
			issue($sformatf("random_%0d", i),
				simt_isa_pkg::opcode_e'(4'($urandom_range(8, 0))),
				$urandom_range(15, 0), $urandom_range(15, 0), $urandom_range(15, 0),
				20'($urandom), num_threads'($urandom));
		end

		while (received != issued)
			@(posedge clk);
		// a few more cycles catch any extra result.
		repeat (10) @(posedge clk);
		if (uut.u_sva.fail_count == 0)
		begin
			$display("Test OK");
			$finish;
		end
		else
			fail_run("a bound protocol assertion failed");
	end

endmodule

// File: compile.f
source/simt_isa_pkg.sv
source/simt_lane_pkg.sv
source/simt_gpr.sv
source/simt_decode.sv
source/simt_execute.sv
source/simt_writeback.sv
source/simt_core.sv
testbench/simt_core_assertions.sv
testbench/simt_core_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and looks for the pass line in the log.

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -j 0 --top-module simt_core_tb -f compile.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# A higher error limit lets the testbench report a failed bound assertion itself.
./obj_dir/Vsimt_core_tb +verilator+error+limit+10 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" "$log"; then
	exit 0
else
	echo "pass line not found in $log"
	exit 1
fi
